// ==== csr_pkg.sv ====
package csr_pkg;

    localparam int XLEN      = 32;
    localparam int CSR_NUM_W = 14;
    localparam int ECODE_W   = 6;

    localparam int ESUBCODE_W = 9;
    localparam logic [ESUBCODE_W-1:0] ESUBCODE_ADEF = '0;

    // Interrupt pending and enable fields
    localparam int INT_W  = 13;
    localparam int SWI_W  = 2;
    localparam int TI_BIT = 11;
    // LIE bit 10 is reserved
    localparam logic [INT_W-1:0] LIE_WRITABLE = 13'h1BFF;

    localparam int PLV_W          = 2;
    localparam int EENTRY_VA_W    = 26;
    localparam int TCFG_INITVAL_W = 30;

    // Counter value when stopped
    localparam logic [XLEN-1:0] TIMER_IDLE = 32'hFFFF_FFFF;

    // Field positions
    localparam int CRMD_IE_BIT        = 2;
    localparam int CRMD_DA_BIT        = 3;
    localparam int CRMD_PG_BIT        = 4;
    localparam int PRMD_PIE_BIT       = 2;
    localparam int EENTRY_VA_LSB      = 6;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int TCFG_EN_BIT        = 0;
    localparam int TCFG_PERIODIC_BIT  = 1;
    localparam int TCFG_INITVAL_LSB   = 2;
    localparam int TICLR_CLR_BIT      = 0;

    typedef enum logic [CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00C,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    typedef enum logic [ECODE_W-1:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0B,
        ECODE_BRK = 6'h0C,
        ECODE_INE = 6'h0D
    } ecode_e;

    // New bits where the mask is set, old bits elsewhere
    function automatic logic [XLEN-1:0] mask_merge(input logic [XLEN-1:0] old_value,
                                                   input logic [XLEN-1:0] wmask,
                                                   input logic [XLEN-1:0] wvalue);
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

// ==== csr_exc_state.sv ====
`timescale 1ns/10ps

module csr_exc_state import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_we,
    input  csr_num_e              csr_num,
    input  logic [XLEN-1:0]       csr_wmask,
    input  logic [XLEN-1:0]       csr_wvalue,
    input  logic                  ertn_flush,
    input  logic                  wb_ex,
    input  logic [XLEN-1:0]       wb_pc,
    input  logic [XLEN-1:0]       wb_vaddr,
    input  ecode_e                wb_ecode,
    input  logic [ESUBCODE_W-1:0] wb_esubcode,
    output logic                  crmd_ie,
    output logic [INT_W-1:0]      ecfg_lie,
    output logic [SWI_W-1:0]      estat_swi,
    output ecode_e                estat_ecode,
    output logic [ESUBCODE_W-1:0] estat_esubcode,
    output logic [XLEN-1:0]       exc_rdata,
    output logic [XLEN-1:0]       csr_eentry_data,
    output logic [XLEN-1:0]       csr_era_pc
);

    logic [PLV_W-1:0]       crmd_plv;
    logic                   crmd_da;
    logic                   crmd_pg;
    logic [PLV_W-1:0]       prmd_pplv;
    logic                   prmd_pie;
    logic [EENTRY_VA_W-1:0] eentry_va;
    logic [XLEN-1:0]        badv;
    logic [XLEN-1:0]        save_q [4];
    logic [1:0]             save_sel;

    logic [XLEN-1:0] crmd_image;
    logic [XLEN-1:0] prmd_image;
    logic [XLEN-1:0] crmd_next;
    logic [XLEN-1:0] prmd_next;
    logic [XLEN-1:0] ecfg_next;
    logic [XLEN-1:0] estat_next;
    logic [XLEN-1:0] era_next;
    logic [XLEN-1:0] eentry_next;
    logic            wr_save;
    logic            addr_err;

    // DATF and DATM are not implemented and read zero
    assign crmd_image = {{(XLEN-5){1'b0}}, crmd_pg, crmd_da, crmd_ie, crmd_plv};
    assign prmd_image = {{(XLEN-3){1'b0}}, prmd_pie, prmd_pplv};
    assign csr_eentry_data = {eentry_va, {EENTRY_VA_LSB{1'b0}}};

    assign crmd_next   = mask_merge(crmd_image, csr_wmask, csr_wvalue);
    assign prmd_next   = mask_merge(prmd_image, csr_wmask, csr_wvalue);
    assign ecfg_next   = mask_merge({{(XLEN-INT_W){1'b0}}, ecfg_lie}, csr_wmask, csr_wvalue);
    assign estat_next  = mask_merge({{(XLEN-SWI_W){1'b0}}, estat_swi}, csr_wmask, csr_wvalue);
    assign era_next    = mask_merge(csr_era_pc, csr_wmask, csr_wvalue);
    assign eentry_next = mask_merge(csr_eentry_data, csr_wmask, csr_wvalue);

    assign save_sel = csr_num[1:0];
    assign wr_save  = csr_we && (csr_num inside {CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3});
    assign addr_err = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);

    // Exception entry beats return, return beats a CSR write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b1;
            crmd_pg  <= 1'b0;
        end else begin
            if (wb_ex) begin
                crmd_plv <= '0;
                crmd_ie  <= 1'b0;
            end else if (ertn_flush) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end else if (csr_we && csr_num == CSR_CRMD) begin
                crmd_plv <= crmd_next[PLV_W-1:0];
                crmd_ie  <= crmd_next[CRMD_IE_BIT];
            end
            if (csr_we && csr_num == CSR_CRMD) begin
                crmd_da <= crmd_next[CRMD_DA_BIT];
                crmd_pg <= crmd_next[CRMD_PG_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv      <= '0;
            prmd_pie       <= 1'b0;
            ecfg_lie       <= '0;
            estat_swi      <= '0;
            estat_ecode    <= ECODE_INT;
            estat_esubcode <= '0;
            csr_era_pc     <= '0;
            eentry_va      <= '0;
            badv           <= '0;
        end else begin
            if (wb_ex) begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
            end else if (csr_we && csr_num == CSR_PRMD) begin
                prmd_pplv <= prmd_next[PLV_W-1:0];
                prmd_pie  <= prmd_next[PRMD_PIE_BIT];
            end
            if (csr_we && csr_num == CSR_ECFG) begin
                ecfg_lie <= ecfg_next[INT_W-1:0] & LIE_WRITABLE;
            end
            // Only the software bits of IS are writable
            if (csr_we && csr_num == CSR_ESTAT) begin
                estat_swi <= estat_next[SWI_W-1:0];
            end
            if (wb_ex) begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
                csr_era_pc     <= wb_pc;
            end else if (csr_we && csr_num == CSR_ERA) begin
                csr_era_pc <= era_next;
            end
            if (csr_we && csr_num == CSR_EENTRY) begin
                eentry_va <= eentry_next[XLEN-1:EENTRY_VA_LSB];
            end
            // Fetch faults record the PC, other address faults the data address
            if (wb_ex && addr_err) begin
                if (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) begin
                    badv <= wb_pc;
                end else begin
                    badv <= wb_vaddr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wr_save) begin
            save_q[save_sel] <= mask_merge(save_q[save_sel], csr_wmask, csr_wvalue);
        end
    end

    always_comb begin
        case (csr_num)
            CSR_CRMD:   exc_rdata = crmd_image;
            CSR_PRMD:   exc_rdata = prmd_image;
            CSR_ECFG:   exc_rdata = {{(XLEN-INT_W){1'b0}}, ecfg_lie};
            CSR_ERA:    exc_rdata = csr_era_pc;
            CSR_BADV:   exc_rdata = badv;
            CSR_EENTRY: exc_rdata = csr_eentry_data;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: exc_rdata = save_q[save_sel];
            default:    exc_rdata = '0;
        endcase
    end

endmodule

// ==== csr_timer.sv ====
`timescale 1ns/10ps

module csr_timer import csr_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            csr_we,
    input  csr_num_e        csr_num,
    input  logic [XLEN-1:0] csr_wmask,
    input  logic [XLEN-1:0] csr_wvalue,
    output logic            timer_int,
    output logic [XLEN-1:0] timer_rdata
);

    logic [XLEN-1:0]           tid;
    logic                      tcfg_en;
    logic                      tcfg_periodic;
    logic [TCFG_INITVAL_W-1:0] tcfg_initval;
    logic [XLEN-1:0]           timer_cnt;

    logic [XLEN-1:0] tcfg_image;
    logic [XLEN-1:0] tcfg_next;
    logic            wr_tcfg;
    logic            ticlr_clr;
    logic            cnt_zero;

    assign tcfg_image = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_next  = mask_merge(tcfg_image, csr_wmask, csr_wvalue);
    assign wr_tcfg    = csr_we && csr_num == CSR_TCFG;
    assign ticlr_clr  = csr_we && csr_num == CSR_TICLR
                        && csr_wmask[TICLR_CLR_BIT] && csr_wvalue[TICLR_CLR_BIT];
    assign cnt_zero   = timer_cnt == '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            tid           <= '0;
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else begin
            if (csr_we && csr_num == CSR_TID) begin
                tid <= mask_merge(tid, csr_wmask, csr_wvalue);
            end
            if (wr_tcfg) begin
                tcfg_en       <= tcfg_next[TCFG_EN_BIT];
                tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
                tcfg_initval  <= tcfg_next[XLEN-1:TCFG_INITVAL_LSB];
            end
        end
    end

    // A one-shot count wraps from zero to TIMER_IDLE and holds there
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= TIMER_IDLE;
        end else if (wr_tcfg && tcfg_next[TCFG_EN_BIT]) begin
            timer_cnt <= {tcfg_next[XLEN-1:TCFG_INITVAL_LSB], 2'b00};
        end else if (tcfg_en && timer_cnt != TIMER_IDLE) begin
            if (cnt_zero && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // Set has priority over clear
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (tcfg_en && cnt_zero) begin
            timer_int <= 1'b1;
        end else if (ticlr_clr) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        case (csr_num)
            CSR_TID:  timer_rdata = tid;
            CSR_TCFG: timer_rdata = tcfg_image;
            CSR_TVAL: timer_rdata = timer_cnt;
            // TICLR is write-only
            default:  timer_rdata = '0;
        endcase
    end

endmodule

// ==== csr_read_mux.sv ====
`timescale 1ns/10ps

module csr_read_mux import csr_pkg::*; (
    input  csr_num_e              csr_num,
    input  logic                  crmd_ie,
    input  logic [INT_W-1:0]      ecfg_lie,
    input  logic [SWI_W-1:0]      estat_swi,
    input  ecode_e                estat_ecode,
    input  logic [ESUBCODE_W-1:0] estat_esubcode,
    input  logic                  timer_int,
    input  logic [XLEN-1:0]       exc_rdata,
    input  logic [XLEN-1:0]       timer_rdata,
    output logic [XLEN-1:0]       csr_rvalue,
    output logic                  has_int
);

    logic [INT_W-1:0] estat_is;
    logic [XLEN-1:0]  estat_image;

    // Hardware and IPI lines are not connected
    always_comb begin
        estat_is                = '0;
        estat_is[SWI_W-1:0]     = estat_swi;
        estat_is[TI_BIT]        = timer_int;
    end

    always_comb begin
        estat_image                                    = '0;
        estat_image[INT_W-1:0]                         = estat_is;
        estat_image[ESTAT_ECODE_LSB +: ECODE_W]        = estat_ecode;
        estat_image[ESTAT_ESUBCODE_LSB +: ESUBCODE_W]  = estat_esubcode;
    end

    // Both units return zero outside their own numbers
    always_comb begin
        if (csr_num == CSR_ESTAT) begin
            csr_rvalue = estat_image;
        end else begin
            csr_rvalue = exc_rdata | timer_rdata;
        end
    end

    assign has_int = ((estat_is & ecfg_lie) != '0) && crmd_ie;

endmodule

// ==== csr_top.sv ====
`timescale 1ns/10ps

module csr_top import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_we,
    input  csr_num_e              csr_num,
    input  logic [XLEN-1:0]       csr_wmask,
    input  logic [XLEN-1:0]       csr_wvalue,
    input  logic                  ertn_flush,
    input  logic                  wb_ex,
    input  logic [XLEN-1:0]       wb_pc,
    input  logic [XLEN-1:0]       wb_vaddr,
    input  ecode_e                wb_ecode,
    input  logic [ESUBCODE_W-1:0] wb_esubcode,
    output logic [XLEN-1:0]       csr_rvalue,
    output logic                  has_int,
    output logic [XLEN-1:0]       csr_eentry_data,
    output logic [XLEN-1:0]       csr_era_pc
);

    logic                  crmd_ie;
    logic [INT_W-1:0]      ecfg_lie;
    logic [SWI_W-1:0]      estat_swi;
    ecode_e                estat_ecode;
    logic [ESUBCODE_W-1:0] estat_esubcode;
    logic [XLEN-1:0]       exc_rdata;
    logic                  timer_int;
    logic [XLEN-1:0]       timer_rdata;

    csr_exc_state u_exc_state (
        .clk             (clk),
        .reset           (reset),
        .csr_we          (csr_we),
        .csr_num         (csr_num),
        .csr_wmask       (csr_wmask),
        .csr_wvalue      (csr_wvalue),
        .ertn_flush      (ertn_flush),
        .wb_ex           (wb_ex),
        .wb_pc           (wb_pc),
        .wb_vaddr        (wb_vaddr),
        .wb_ecode        (wb_ecode),
        .wb_esubcode     (wb_esubcode),
        .crmd_ie         (crmd_ie),
        .ecfg_lie        (ecfg_lie),
        .estat_swi       (estat_swi),
        .estat_ecode     (estat_ecode),
        .estat_esubcode  (estat_esubcode),
        .exc_rdata       (exc_rdata),
        .csr_eentry_data (csr_eentry_data),
        .csr_era_pc      (csr_era_pc)
    );

    csr_timer u_timer (
        .clk         (clk),
        .reset       (reset),
        .csr_we      (csr_we),
        .csr_num     (csr_num),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .timer_int   (timer_int),
        .timer_rdata (timer_rdata)
    );

    csr_read_mux u_read_mux (
        .csr_num        (csr_num),
        .crmd_ie        (crmd_ie),
        .ecfg_lie       (ecfg_lie),
        .estat_swi      (estat_swi),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .timer_int      (timer_int),
        .exc_rdata      (exc_rdata),
        .timer_rdata    (timer_rdata),
        .csr_rvalue     (csr_rvalue),
        .has_int        (has_int)
    );

endmodule

// ==== csr_checker.sv ====
`timescale 1ns/10ps

module csr_checker import csr_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic            wb_ex,
    input logic [XLEN-1:0] wb_pc,
    input logic            has_int,
    input logic [XLEN-1:0] csr_era_pc,
    input logic [XLEN-1:0] csr_eentry_data
);

    int fail_count = 0;

    // Nothing can be pending right after reset
    no_int_after_reset: assert property (@(posedge clk) reset |=> !has_int)
        else begin
            fail_count++;
            $error("has_int is high in the cycle after reset");
        end

    era_follows_wb_pc: assert property (@(posedge clk) disable iff (reset)
                                        wb_ex |=> csr_era_pc == $past(wb_pc))
        else begin
            fail_count++;
            $error("ERA does not hold the PC of the last exception");
        end

    // Entry address is 64-byte aligned
    eentry_aligned: assert property (@(posedge clk) disable iff (reset)
                                     csr_eentry_data[5:0] == 6'h0)
        else begin
            fail_count++;
            $error("EENTRY has nonzero low bits");
        end

endmodule

bind csr_top csr_checker u_checker (
    .clk             (clk),
    .reset           (reset),
    .wb_ex           (wb_ex),
    .wb_pc           (wb_pc),
    .has_int         (has_int),
    .csr_era_pc      (csr_era_pc),
    .csr_eentry_data (csr_eentry_data)
);

// ==== tb_csr.sv ====
`timescale 1ns/10ps

module tb_csr import csr_pkg::*; ();

    logic                  clk;
    logic                  reset;
    logic                  csr_we;
    csr_num_e              csr_num;
    logic [XLEN-1:0]       csr_wmask;
    logic [XLEN-1:0]       csr_wvalue;
    logic                  ertn_flush;
    logic                  wb_ex;
    logic [XLEN-1:0]       wb_pc;
    logic [XLEN-1:0]       wb_vaddr;
    ecode_e                wb_ecode;
    logic [ESUBCODE_W-1:0] wb_esubcode;
    logic [XLEN-1:0]       csr_rvalue;
    logic                  has_int;
    logic [XLEN-1:0]       csr_eentry_data;
    logic [XLEN-1:0]       csr_era_pc;

    integer seed;
    int     error_count;
    int     check_count;

    csr_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [XLEN-1:0] actual,
                         input logic [XLEN-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, actual, expected);
        end
    endtask

    task automatic csr_write(input csr_num_e num, input logic [XLEN-1:0] mask,
                             input logic [XLEN-1:0] value);
        @(posedge clk);
        csr_we     <= 1'b1;
        csr_num    <= num;
        csr_wmask  <= mask;
        csr_wvalue <= value;
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    task automatic csr_read(input csr_num_e num, output logic [XLEN-1:0] value);
        @(posedge clk);
        csr_num <= num;
        @(negedge clk);
        value = csr_rvalue;
    endtask

    task automatic read_check(input csr_num_e num, input logic [XLEN-1:0] expected);
        logic [XLEN-1:0] value;
        csr_read(num, value);
        check(num.name(), value, expected);
    endtask

    task automatic raise_exception(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] vaddr,
                                   input ecode_e ecode, input logic [ESUBCODE_W-1:0] subcode);
        @(posedge clk);
        wb_ex       <= 1'b1;
        wb_pc       <= pc;
        wb_vaddr    <= vaddr;
        wb_ecode    <= ecode;
        wb_esubcode <= subcode;
        @(posedge clk);
        wb_ex <= 1'b0;
    endtask

    task automatic return_from_exception();
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    // Polls ESTAT until the timer bit shows up
    task automatic wait_timer_pending(input int max_cycles);
        int cycles;
        cycles = 0;
        @(posedge clk);
        csr_num <= CSR_ESTAT;
        @(negedge clk);
        while (!csr_rvalue[TI_BIT] && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!csr_rvalue[TI_BIT]) begin
            error_count++;
            $display("timer interrupt did not become pending within %0d cycles", max_cycles);
        end
    endtask

    task automatic check_has_int(input logic expected);
        @(negedge clk);
        check("has_int", 32'(has_int), 32'(expected));
    endtask

    task automatic test_reset_and_masked_writes();
        csr_num_e zero_regs [13] = '{CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV,
                                     CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                                     CSR_TID, CSR_TCFG, CSR_TICLR};
        csr_num_e        regs [6] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                                      CSR_EENTRY, CSR_TID};
        logic [XLEN-1:0] model [6];
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] rdata;
        read_check(CSR_CRMD, 32'h8);
        for (int i = 0; i < 13; i++) begin
            read_check(zero_regs[i], 32'h0);
        end
        read_check(CSR_TVAL, TIMER_IDLE);
        csr_read(csr_num_e'(14'h010), rdata);
        check("unknown csr", rdata, 32'h0);
        for (int i = 0; i < 6; i++) begin
            model[i] = '0;
        end
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 6; i++) begin
                mask  = $random(seed);
                value = $random(seed);
                csr_write(regs[i], mask, value);
                model[i] = (model[i] & ~mask) | (value & mask);
                // EENTRY keeps its low six bits at zero
                if (regs[i] == CSR_EENTRY) begin
                    model[i][5:0] = 6'h0;
                end
                read_check(regs[i], model[i]);
                if (regs[i] == CSR_EENTRY) begin
                    check("csr_eentry_data", csr_eentry_data, model[i]);
                end
            end
        end
    endtask

    task automatic test_exception_entry_return();
        logic [XLEN-1:0] pc;
        pc = $random(seed) & ~32'h3;
        csr_write(CSR_CRMD, 32'h7, 32'h7);
        read_check(CSR_CRMD, 32'hF);
        raise_exception(pc, 32'h0, ECODE_SYS, 9'h5);
        read_check(CSR_CRMD, 32'h8);
        read_check(CSR_PRMD, 32'h7);
        read_check(CSR_ERA, pc);
        check("csr_era_pc", csr_era_pc, pc);
        // Ecode 0xB, EsubCode 0x5, no pending bits
        read_check(CSR_ESTAT, 32'h014B_0000);
        return_from_exception();
        read_check(CSR_CRMD, 32'hF);
    endtask

    task automatic test_bad_address();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] vaddr;
        logic [XLEN-1:0] badv;
        pc    = $random(seed);
        vaddr = $random(seed);
        raise_exception(pc, vaddr, ECODE_ADE, ESUBCODE_ADEF);
        read_check(CSR_BADV, pc);
        pc    = $random(seed);
        vaddr = $random(seed);
        raise_exception(pc, vaddr, ECODE_ALE, 9'h0);
        read_check(CSR_BADV, vaddr);
        badv  = vaddr;
        pc    = $random(seed);
        vaddr = $random(seed);
        raise_exception(pc, vaddr, ECODE_SYS, 9'h0);
        read_check(CSR_BADV, badv);
    endtask

    task automatic test_one_shot_timer();
        // initval 3, one-shot, enabled
        csr_write(CSR_TCFG, 32'hFFFF_FFFF, 32'hD);
        read_check(CSR_TCFG, 32'hD);
        wait_timer_pending(40);
        read_check(CSR_TVAL, TIMER_IDLE);
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        @(posedge clk);
        csr_num <= CSR_ESTAT;
        repeat (30) begin
            @(negedge clk);
            check("estat.ti", 32'(csr_rvalue[TI_BIT]), 32'h0);
        end
    endtask

    task automatic test_periodic_timer_and_gating();
        logic [XLEN-1:0] rdata;
        csr_write(CSR_CRMD, 32'h4, 32'h0);
        csr_write(CSR_ECFG, 32'hFFFF_FFFF, 32'h0);
        // initval 2, periodic, enabled
        csr_write(CSR_TCFG, 32'hFFFF_FFFF, 32'hB);
        repeat (3) begin
            wait_timer_pending(40);
            csr_write(CSR_TICLR, 32'h1, 32'h1);
            csr_read(CSR_ESTAT, rdata);
            check("estat.ti", 32'(rdata[TI_BIT]), 32'h0);
        end
        wait_timer_pending(40);
        check_has_int(1'b0);
        csr_write(CSR_ECFG, 32'hFFFF_FFFF, 32'h800);
        check_has_int(1'b0);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        check_has_int(1'b1);
        csr_write(CSR_ECFG, 32'hFFFF_FFFF, 32'h0);
        check_has_int(1'b0);
        csr_write(CSR_ECFG, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        read_check(CSR_ECFG, 32'h1BFF);
        check_has_int(1'b1);
        csr_write(CSR_CRMD, 32'h4, 32'h0);
        check_has_int(1'b0);
        // Stop the timer and drop its pending bit
        csr_write(CSR_TCFG, 32'hFFFF_FFFF, 32'h0);
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        csr_read(CSR_ESTAT, rdata);
        check("estat.ti", 32'(rdata[TI_BIT]), 32'h0);
    endtask

    task automatic test_software_interrupts();
        logic [XLEN-1:0] rdata;
        csr_write(CSR_ECFG, 32'hFFFF_FFFF, 32'h3);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        check_has_int(1'b0);
        csr_write(CSR_ESTAT, 32'h3, 32'h1);
        check_has_int(1'b1);
        csr_read(CSR_ESTAT, rdata);
        check("estat.is", 32'(rdata[INT_W-1:0]), 32'h1);
        csr_write(CSR_ESTAT, 32'h3, 32'h0);
        check_has_int(1'b0);
        csr_write(CSR_ESTAT, 32'h3, 32'h2);
        check_has_int(1'b1);
        // SWI1 pending but masked off
        csr_write(CSR_ECFG, 32'hFFFF_FFFF, 32'h1);
        check_has_int(1'b0);
        csr_write(CSR_ESTAT, 32'h3, 32'h0);
        check_has_int(1'b0);
    endtask

    initial begin
        seed        = 32'hc8ea;
        error_count = 0;
        check_count = 0;
        reset       = 1'b1;
        csr_we      = 1'b0;
        csr_num     = CSR_CRMD;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        ertn_flush  = 1'b0;
        wb_ex       = 1'b0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        wb_ecode    = ECODE_INT;
        wb_esubcode = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        test_reset_and_masked_writes();
        test_exception_entry_return();
        test_bad_address();
        test_one_shot_timer();
        test_periodic_timer_and_gating();
        test_software_interrupts();

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, u_dut.u_checker.fail_count);
        if (error_count == 0 && u_dut.u_checker.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
csr_pkg.sv
csr_exc_state.sv
csr_timer.sv
csr_read_mux.sv
csr_top.sv
csr_checker.sv
tb_csr.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_csr
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the simulation output
sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
